/* source/mips_ex_defines.svh */
`ifndef MIPS_EX_DEFINES_SVH
`define MIPS_EX_DEFINES_SVH

// ======================================================================
// Execute stage dimensions
// ======================================================================

// Data word width
`define EX_XLEN 32

// One multiply or divide bit per iteration
`define MULDIV_ITERS 32

// Wide enough to hold MULDIV_ITERS
`define ITER_CNT_W 6

// Return address skips the delay slot
`define PC_LINK_OFFSET 8

`endif

/* source/mips_ex_pkg.sv */
`include "mips_ex_defines.svh"

package mips_ex_pkg;

    // ==================================================================
    // Opcodes and FSM states
    // ==================================================================

    typedef enum logic [5:0] {
        ADD,
        ADDU,
        ADDI,
        ADDIU,
        SUB,
        SUBU,
        AND,
        ANDI,
        OR,
        ORI,
        XOR,
        XORI,
        NOR,
        LUI,
        SLL,
        SRL,
        SRA,
        SLLV,
        SRLV,
        SRAV,
        SLT,
        SLTU,
        SLTI,
        SLTIU,
        MOV,         // Value part of the conditional move
        LINK,        // PC plus link offset
        CACHE,       // Cache address as srca plus immediate
        MULT,
        MULTU,
        DIV,
        DIVU,
        MFHI,
        MFLO
    } alu_op_e;

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        FIX,
        DONE
    } muldiv_state_e;

    // ==================================================================
    // Bundles between caller, top and the HI/LO path
    // ==================================================================

    typedef struct packed {
        alu_op_e              op;
        logic [`EX_XLEN-1:0]  srca;
        logic [`EX_XLEN-1:0]  srcb;
        logic [4:0]           shamt;
        logic [15:0]          imm16;
        logic [`EX_XLEN-1:0]  pc;
    } ex_req_t;

    typedef struct packed {
        logic [`EX_XLEN-1:0]  result;
        logic                 overflow;
        logic                 is_hilo;    // Read back from HI or LO
    } ex_resp_t;

    typedef struct packed {
        logic                 is_div;
        logic                 is_signed;
        logic [`EX_XLEN-1:0]  a;
        logic [`EX_XLEN-1:0]  b;
    } muldiv_cmd_t;

endpackage

/* source/mips_alu.sv */
`include "mips_ex_defines.svh"

module mips_alu (
    input  mips_ex_pkg::alu_op_e  i_op,
    input  logic [`EX_XLEN-1:0]   i_srca,
    input  logic [`EX_XLEN-1:0]   i_srcb,
    input  logic [4:0]            i_shamt,
    input  logic [15:0]           i_imm16,
    input  logic [`EX_XLEN-1:0]   i_pc,
    output logic [`EX_XLEN-1:0]   o_result,
    output logic                  o_overflow
);

    // ==================================================================
    // Immediate extension
    // ==================================================================
    logic                 ext_zero;
    logic                 ext_upper;
    logic                 ext_sign;
    logic [`EX_XLEN-1:0]  imm32;

    assign ext_zero  = i_op inside {mips_ex_pkg::ANDI, mips_ex_pkg::ORI, mips_ex_pkg::XORI};
    assign ext_upper = (i_op == mips_ex_pkg::LUI);
    assign ext_sign  = !(ext_zero | ext_upper);
    assign imm32 = ({`EX_XLEN{ext_zero}}  & {16'b0, i_imm16})
                 | ({`EX_XLEN{ext_upper}} & {i_imm16, 16'b0})
                 | ({`EX_XLEN{ext_sign}}  & {{16{i_imm16[15]}}, i_imm16});

    // Add and subtract
    logic                 is_arith;
    logic                 arith_reg;
    logic                 arith_sub;
    logic [`EX_XLEN-1:0]  arith_b;
    logic [`EX_XLEN:0]    add_ext;
    logic [`EX_XLEN:0]    sub_ext;
    logic [`EX_XLEN-1:0]  arith_r;

    assign is_arith  = i_op inside {mips_ex_pkg::ADD, mips_ex_pkg::ADDU, mips_ex_pkg::ADDI,
                                    mips_ex_pkg::ADDIU, mips_ex_pkg::SUB, mips_ex_pkg::SUBU};
    assign arith_reg = i_op inside {mips_ex_pkg::ADD, mips_ex_pkg::ADDU,
                                    mips_ex_pkg::SUB, mips_ex_pkg::SUBU};
    assign arith_sub = i_op inside {mips_ex_pkg::SUB, mips_ex_pkg::SUBU};
    assign arith_b   = arith_reg ? i_srcb : imm32;
    assign add_ext   = {i_srca[`EX_XLEN-1], i_srca} + {arith_b[`EX_XLEN-1], arith_b};
    assign sub_ext   = {i_srca[`EX_XLEN-1], i_srca} - {arith_b[`EX_XLEN-1], arith_b};
    assign arith_r   = arith_sub ? sub_ext[`EX_XLEN-1:0] : add_ext[`EX_XLEN-1:0];

    // Sign-extended copy disagrees with the MSB on overflow
    assign o_overflow =
        ((i_op inside {mips_ex_pkg::ADD, mips_ex_pkg::ADDI}) &
         (add_ext[`EX_XLEN] != add_ext[`EX_XLEN-1])) |
        ((i_op == mips_ex_pkg::SUB) & (sub_ext[`EX_XLEN] != sub_ext[`EX_XLEN-1]));

    // Logic, immediate logic and LUI
    logic                 is_logic;
    logic [`EX_XLEN-1:0]  logic_b;
    logic [`EX_XLEN-1:0]  logic_r;

    assign is_logic = i_op inside {mips_ex_pkg::AND, mips_ex_pkg::ANDI, mips_ex_pkg::OR,
                                   mips_ex_pkg::ORI, mips_ex_pkg::XOR, mips_ex_pkg::XORI,
                                   mips_ex_pkg::NOR, mips_ex_pkg::LUI};
    assign logic_b  = ext_zero ? imm32 : i_srcb;

    always_comb begin
        case (i_op)
            mips_ex_pkg::AND, mips_ex_pkg::ANDI: logic_r = i_srca & logic_b;
            mips_ex_pkg::OR,  mips_ex_pkg::ORI:  logic_r = i_srca | logic_b;
            mips_ex_pkg::XOR, mips_ex_pkg::XORI: logic_r = i_srca ^ logic_b;
            mips_ex_pkg::NOR:                    logic_r = ~(i_srca | logic_b);
            default:                             logic_r = imm32;    // LUI
        endcase
    end

    // Shifts by constant or by register
    logic                 is_shift;
    logic [4:0]           shift_amt;
    logic [`EX_XLEN-1:0]  shift_r;

    assign is_shift  = i_op inside {mips_ex_pkg::SLL, mips_ex_pkg::SRL, mips_ex_pkg::SRA,
                                    mips_ex_pkg::SLLV, mips_ex_pkg::SRLV, mips_ex_pkg::SRAV};
    assign shift_amt = (i_op inside {mips_ex_pkg::SLL, mips_ex_pkg::SRL, mips_ex_pkg::SRA}) ?
                       i_shamt : i_srca[4:0];

    always_comb begin
        case (i_op)
            mips_ex_pkg::SLL, mips_ex_pkg::SLLV: shift_r = i_srcb << shift_amt;
            mips_ex_pkg::SRL, mips_ex_pkg::SRLV: shift_r = i_srcb >> shift_amt;
            default: shift_r = $unsigned($signed(i_srcb) >>> shift_amt);
        endcase
    end

    // Set-less-than family
    logic                 is_cmp;
    logic [`EX_XLEN-1:0]  cmp_b;
    logic                 cmp_lt;
    logic [`EX_XLEN-1:0]  cmp_r;

    assign is_cmp = i_op inside {mips_ex_pkg::SLT, mips_ex_pkg::SLTU,
                                 mips_ex_pkg::SLTI, mips_ex_pkg::SLTIU};
    assign cmp_b  = (i_op inside {mips_ex_pkg::SLTI, mips_ex_pkg::SLTIU}) ? imm32 : i_srcb;
    assign cmp_lt = (i_op inside {mips_ex_pkg::SLT, mips_ex_pkg::SLTI}) ?
                    ($signed(i_srca) < $signed(cmp_b)) : (i_srca < cmp_b);
    assign cmp_r  = {{(`EX_XLEN-1){1'b0}}, cmp_lt};

    // ==================================================================
    // Pass-through, link, cache address and final select
    // ==================================================================
    logic is_mov;
    logic is_link;
    logic is_cache;

    assign is_mov   = (i_op == mips_ex_pkg::MOV);
    assign is_link  = (i_op == mips_ex_pkg::LINK);
    assign is_cache = (i_op == mips_ex_pkg::CACHE);

    // At most one class is active and the others contribute zero
    assign o_result = ({`EX_XLEN{is_arith}} & arith_r)
                    | ({`EX_XLEN{is_logic}} & logic_r)
                    | ({`EX_XLEN{is_shift}} & shift_r)
                    | ({`EX_XLEN{is_cmp}}   & cmp_r)
                    | ({`EX_XLEN{is_mov}}   & i_srca)
                    | ({`EX_XLEN{is_link}}  & (i_pc + `EX_XLEN'(`PC_LINK_OFFSET)))
                    | ({`EX_XLEN{is_cache}} & (i_srca + imm32));

endmodule

/* source/mips_muldiv_fsm.sv */
`include "mips_ex_defines.svh"

module mips_muldiv_fsm (
    input  logic i_clk,
    input  logic i_rst_n,
    input  logic i_start,
    input  logic i_last,
    output logic o_load,
    output logic o_step,
    output logic o_fix,
    output logic o_commit,
    output logic o_busy
);

    mips_ex_pkg::muldiv_state_e state_q;
    mips_ex_pkg::muldiv_state_e state_d;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q <= mips_ex_pkg::IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            mips_ex_pkg::IDLE: begin
                if (i_start) begin
                    state_d = mips_ex_pkg::RUN;
                end
            end
            mips_ex_pkg::RUN: begin
                if (i_last) begin
                    state_d = mips_ex_pkg::FIX;    // Final iteration this cycle
                end
            end
            mips_ex_pkg::FIX:  state_d = mips_ex_pkg::DONE;
            mips_ex_pkg::DONE: state_d = mips_ex_pkg::IDLE;
            default:           state_d = mips_ex_pkg::IDLE;
        endcase
    end

    // ==================================================================
    // Control strobes to counter and HI/LO datapath
    // ==================================================================
    assign o_load   = (state_q == mips_ex_pkg::IDLE) && i_start;
    assign o_step   = (state_q == mips_ex_pkg::RUN);
    assign o_fix    = (state_q == mips_ex_pkg::FIX);
    assign o_commit = (state_q == mips_ex_pkg::DONE);
    assign o_busy   = (state_q != mips_ex_pkg::IDLE);

    // Caller must hold off new multiply/divide work while busy
    a_no_start_busy: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        i_start |-> !o_busy
    );

    // RUN spans exactly one full count of the iteration counter
    a_run_length: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        $fell(state_q == mips_ex_pkg::RUN) |-> $past(o_load, `MULDIV_ITERS + 1)
    );

endmodule

/* source/mips_iter_counter.sv */
`include "mips_ex_defines.svh"

module mips_iter_counter (
    input  logic i_clk,
    input  logic i_rst_n,
    input  logic i_load,
    input  logic i_step,
    output logic o_last
);

    logic [`ITER_CNT_W-1:0] cnt_q;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            cnt_q <= '0;
        end else if (i_load) begin
            cnt_q <= `ITER_CNT_W'(`MULDIV_ITERS);
        end else if (i_step) begin
            cnt_q <= cnt_q - 1'b1;
        end
    end

    assign o_last = (cnt_q == `ITER_CNT_W'(1));    // Remaining iteration is the final one

    // FSM must leave RUN before the count runs out
    a_no_step_at_zero: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        i_step |-> (cnt_q != '0)
    );

endmodule

/* source/mips_hilo_unit.sv */
`include "mips_ex_defines.svh"

module mips_hilo_unit (
    input  logic                      i_clk,
    input  logic                      i_rst_n,
    input  mips_ex_pkg::muldiv_cmd_t  i_cmd,
    input  logic                      i_load,
    input  logic                      i_step,
    input  logic                      i_fix,
    input  logic                      i_commit,
    output logic [`EX_XLEN-1:0]       o_hi,
    output logic [`EX_XLEN-1:0]       o_lo
);

    localparam int XL = `EX_XLEN;

    // Upper half holds partial product or remainder and lower half multiplier or quotient
    logic [2*XL-1:0]  acc_q;
    logic [XL-1:0]    opnd_q;      // Multiplicand or divisor magnitude
    logic             is_div_q;
    logic             neg_lo_q;    // Product or quotient sign
    logic             neg_hi_q;    // Remainder follows the dividend
    logic [XL-1:0]    hi_q;
    logic [XL-1:0]    lo_q;

    // ==================================================================
    // Operand magnitudes on load
    // ==================================================================
    logic          a_neg;
    logic          b_neg;
    logic [XL-1:0] a_abs;
    logic [XL-1:0] b_abs;

    assign a_neg = i_cmd.is_signed & i_cmd.a[XL-1];
    assign b_neg = i_cmd.is_signed & i_cmd.b[XL-1];
    assign a_abs = a_neg ? (~i_cmd.a + 1'b1) : i_cmd.a;
    assign b_abs = b_neg ? (~i_cmd.b + 1'b1) : i_cmd.b;

    // One shift-add multiply bit
    logic [XL:0]     mul_sum;
    logic [2*XL-1:0] mul_next;

    assign mul_sum  = {1'b0, acc_q[2*XL-1:XL]} + ({1'b0, opnd_q} & {(XL+1){acc_q[0]}});
    assign mul_next = {mul_sum, acc_q[XL-1:1]};

    // One restoring-divide bit
    logic [XL:0]     div_shift;
    logic [XL:0]     div_diff;
    logic [2*XL-1:0] div_next;

    assign div_shift = {acc_q[2*XL-1:XL], acc_q[XL-1]};
    assign div_diff  = div_shift - {1'b0, opnd_q};
    assign div_next  = div_diff[XL] ? {div_shift[XL-1:0], acc_q[XL-2:0], 1'b0}    // Restore
                                    : {div_diff[XL-1:0],  acc_q[XL-2:0], 1'b1};

    // Sign correction
    logic [2*XL-1:0] fix_next;

    always_comb begin
        if (is_div_q) begin
            fix_next[2*XL-1:XL] = neg_hi_q ? (~acc_q[2*XL-1:XL] + 1'b1) : acc_q[2*XL-1:XL];
            fix_next[XL-1:0]    = neg_lo_q ? (~acc_q[XL-1:0] + 1'b1) : acc_q[XL-1:0];
        end else begin
            fix_next = neg_lo_q ? (~acc_q + 1'b1) : acc_q;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_load) begin
            acc_q    <= {{XL{1'b0}}, a_abs};
            opnd_q   <= b_abs;
            is_div_q <= i_cmd.is_div;
            neg_lo_q <= a_neg ^ b_neg;
            neg_hi_q <= a_neg;
        end else if (i_step) begin
            acc_q <= is_div_q ? div_next : mul_next;
        end else if (i_fix) begin
            acc_q <= fix_next;
        end
    end

    // ==================================================================
    // Architectural HI/LO
    // ==================================================================
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            hi_q <= '0;
            lo_q <= '0;
        end else if (i_commit) begin
            hi_q <= acc_q[2*XL-1:XL];
            lo_q <= acc_q[XL-1:0];
        end
    end

    assign o_hi = hi_q;
    assign o_lo = lo_q;

endmodule

/* source/mips_ex_top.sv */
`include "mips_ex_defines.svh"

module mips_ex_top (
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    input  logic                   i_req_valid,
    input  mips_ex_pkg::ex_req_t   i_req,
    output logic                   o_resp_valid,
    output mips_ex_pkg::ex_resp_t  o_resp,
    output logic                   o_busy
);

    // ==================================================================
    // Opcode class decode
    // ==================================================================
    logic                      is_muldiv;
    logic                      is_hilo_rd;
    logic                      start;
    mips_ex_pkg::muldiv_cmd_t  cmd;

    assign is_muldiv  = i_req.op inside {mips_ex_pkg::MULT, mips_ex_pkg::MULTU,
                                         mips_ex_pkg::DIV, mips_ex_pkg::DIVU};
    assign is_hilo_rd = i_req.op inside {mips_ex_pkg::MFHI, mips_ex_pkg::MFLO};
    assign start      = i_req_valid & is_muldiv;

    assign cmd.is_div    = i_req.op inside {mips_ex_pkg::DIV, mips_ex_pkg::DIVU};
    assign cmd.is_signed = i_req.op inside {mips_ex_pkg::MULT, mips_ex_pkg::DIV};
    assign cmd.a         = i_req.srca;
    assign cmd.b         = i_req.srcb;

    // Single-cycle path
    logic [`EX_XLEN-1:0] alu_result;
    logic                alu_overflow;

    mips_alu u_alu (
        .i_op       (i_req.op),
        .i_srca     (i_req.srca),
        .i_srcb     (i_req.srcb),
        .i_shamt    (i_req.shamt),
        .i_imm16    (i_req.imm16),
        .i_pc       (i_req.pc),
        .o_result   (alu_result),
        .o_overflow (alu_overflow)
    );

    // Multiply/divide path
    logic                load;
    logic                step;
    logic                fix;
    logic                commit;
    logic                last;
    logic [`EX_XLEN-1:0] hi;
    logic [`EX_XLEN-1:0] lo;

    mips_muldiv_fsm u_fsm (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_start  (start),
        .i_last   (last),
        .o_load   (load),
        .o_step   (step),
        .o_fix    (fix),
        .o_commit (commit),
        .o_busy   (o_busy)
    );

    mips_iter_counter u_iter_cnt (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_load  (load),
        .i_step  (step),
        .o_last  (last)
    );

    mips_hilo_unit u_hilo (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_cmd    (cmd),
        .i_load   (load),
        .i_step   (step),
        .i_fix    (fix),
        .i_commit (commit),
        .o_hi     (hi),
        .o_lo     (lo)
    );

    // ==================================================================
    // Response register
    // ==================================================================
    mips_ex_pkg::ex_resp_t resp_d;
    mips_ex_pkg::ex_resp_t resp_q;
    logic                  resp_valid_q;

    always_comb begin
        resp_d.overflow = alu_overflow;
        resp_d.is_hilo  = is_hilo_rd;
        if (is_hilo_rd) begin
            resp_d.result = (i_req.op == mips_ex_pkg::MFHI) ? hi : lo;
        end else begin
            resp_d.result = alu_result;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            resp_valid_q <= 1'b0;
        end else begin
            resp_valid_q <= i_req_valid & !is_muldiv;    // Muldiv itself has no response
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_req_valid & !is_muldiv) begin
            resp_q <= resp_d;
        end
    end

    assign o_resp_valid = resp_valid_q;
    assign o_resp       = resp_q;

endmodule

/* tests/tb_clock_gen.sv */
module tb_clock_gen (
    output logic o_clk,
    output logic o_rst_n
);

    initial begin
        o_clk = 1'b0;
        forever #2 o_clk = ~o_clk;    // Period 4
    end

    initial begin
        o_rst_n = 1'b0;
        repeat (10) @(posedge o_clk);
        o_rst_n <= 1'b1;
    end

endmodule

/* tests/tb_mips_ex.sv */
`include "mips_ex_defines.svh"

module tb_mips_ex;

    localparam int MULDIV_BUDGET = `MULDIV_ITERS + 8;    // Cycles allowed per muldiv op
    localparam int N_ARITH       = 50;
    localparam int N_LOGIC       = 63;                   // Three rounds over 21 opcodes
    localparam int N_MULDIV_OPS  = 17;
    localparam int N_SINGLE      = 2 + (N_ARITH + 2) + N_LOGIC + 2 * 16 + 7;
    localparam int CYCLE_LIMIT   = MULDIV_BUDGET * N_MULDIV_OPS + 4 * N_SINGLE + 200;

    logic                   clk;
    logic                   rst_n;
    logic                   req_valid;
    mips_ex_pkg::ex_req_t   req;
    logic                   resp_valid;
    mips_ex_pkg::ex_resp_t  resp;
    logic                   busy;

    logic [31:0] rng_state = 32'd28191;
    logic [31:0] exp_hi;
    logic [31:0] exp_lo;
    int          check_count = 0;
    int          err_count = 0;
    int          chk_base = 0;
    int          err_base = 0;
    int          cycles = 0;

    mips_ex_pkg::alu_op_e arith_ops [6] = '{mips_ex_pkg::ADD, mips_ex_pkg::ADDU,
        mips_ex_pkg::ADDI, mips_ex_pkg::ADDIU, mips_ex_pkg::SUB, mips_ex_pkg::SUBU};
    mips_ex_pkg::alu_op_e logic_ops [21] = '{mips_ex_pkg::AND, mips_ex_pkg::ANDI,
        mips_ex_pkg::OR, mips_ex_pkg::ORI, mips_ex_pkg::XOR, mips_ex_pkg::XORI,
        mips_ex_pkg::NOR, mips_ex_pkg::LUI, mips_ex_pkg::SLL, mips_ex_pkg::SRL,
        mips_ex_pkg::SRA, mips_ex_pkg::SLLV, mips_ex_pkg::SRLV, mips_ex_pkg::SRAV,
        mips_ex_pkg::SLT, mips_ex_pkg::SLTU, mips_ex_pkg::SLTI, mips_ex_pkg::SLTIU,
        mips_ex_pkg::MOV, mips_ex_pkg::LINK, mips_ex_pkg::CACHE};

    tb_clock_gen u_clk_gen (
        .o_clk   (clk),
        .o_rst_n (rst_n)
    );

    mips_ex_top dut_i (
        .i_clk        (clk),
        .i_rst_n      (rst_n),
        .i_req_valid  (req_valid),
        .i_req        (req),
        .o_resp_valid (resp_valid),
        .o_resp       (resp),
        .o_busy       (busy)
    );

    // ==================================================================
    // Stimulus source and reference model
    // ==================================================================
    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic mips_ex_pkg::ex_req_t make_req(input mips_ex_pkg::alu_op_e op,
        input logic [31:0] a, input logic [31:0] b, input logic [4:0] sh,
        input logic [15:0] imm, input logic [31:0] pc);
        mips_ex_pkg::ex_req_t r;
        r.op    = op;
        r.srca  = a;
        r.srcb  = b;
        r.shamt = sh;
        r.imm16 = imm;
        r.pc    = pc;
        return r;
    endfunction

    // Returns {overflow, result}
    function automatic logic [32:0] alu_model(input mips_ex_pkg::ex_req_t r);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] simm;
        logic [31:0] zimm;
        logic [31:0] res;
        logic        ovf;
        a    = r.srca;
        b    = r.srcb;
        simm = {{16{r.imm16[15]}}, r.imm16};
        zimm = {16'h0, r.imm16};
        res  = '0;
        ovf  = 1'b0;
        case (r.op)
            mips_ex_pkg::ADD, mips_ex_pkg::ADDU: res = a + b;
            mips_ex_pkg::ADDI, mips_ex_pkg::ADDIU: res = a + simm;
            mips_ex_pkg::SUB, mips_ex_pkg::SUBU: res = a - b;
            mips_ex_pkg::AND:   res = a & b;
            mips_ex_pkg::ANDI:  res = a & zimm;
            mips_ex_pkg::OR:    res = a | b;
            mips_ex_pkg::ORI:   res = a | zimm;
            mips_ex_pkg::XOR:   res = a ^ b;
            mips_ex_pkg::XORI:  res = a ^ zimm;
            mips_ex_pkg::NOR:   res = ~(a | b);
            mips_ex_pkg::LUI:   res = {r.imm16, 16'h0};
            mips_ex_pkg::SLL:   res = b << r.shamt;
            mips_ex_pkg::SRL:   res = b >> r.shamt;
            mips_ex_pkg::SRA:   res = $signed(b) >>> r.shamt;
            mips_ex_pkg::SLLV:  res = b << a[4:0];
            mips_ex_pkg::SRLV:  res = b >> a[4:0];
            mips_ex_pkg::SRAV:  res = $signed(b) >>> a[4:0];
            mips_ex_pkg::SLT:   res = {31'h0, $signed(a) < $signed(b)};
            mips_ex_pkg::SLTU:  res = {31'h0, a < b};
            mips_ex_pkg::SLTI:  res = {31'h0, $signed(a) < $signed(simm)};
            mips_ex_pkg::SLTIU: res = {31'h0, a < simm};
            mips_ex_pkg::MOV:   res = a;
            mips_ex_pkg::LINK:  res = r.pc + 32'd8;
            mips_ex_pkg::CACHE: res = a + simm;
            default:            res = '0;
        endcase
        // Signed overflow when operand signs agree and the result sign flips
        if (r.op == mips_ex_pkg::ADD) begin
            ovf = (a[31] == b[31]) && (res[31] != a[31]);
        end else if (r.op == mips_ex_pkg::ADDI) begin
            ovf = (a[31] == simm[31]) && (res[31] != a[31]);
        end else if (r.op == mips_ex_pkg::SUB) begin
            ovf = (a[31] != b[31]) && (res[31] != a[31]);
        end
        return {ovf, res};
    endfunction

    function automatic logic [63:0] mul_model(input logic sgn, input logic [31:0] a,
        input logic [31:0] b);
        longint p;
        if (sgn) begin
            p = longint'($signed(a)) * longint'($signed(b));
            return p;
        end
        return {32'h0, a} * {32'h0, b};
    endfunction

    // Returns {remainder, quotient} with the quotient rounded toward zero
    function automatic logic [63:0] div_model(input logic sgn, input logic [31:0] a,
        input logic [31:0] b);
        longint      sa;
        longint      sb;
        logic [31:0] q;
        logic [31:0] r;
        if (!sgn && b == 32'h0) begin
            q = '1;
            r = a;
        end else if (sgn) begin
            sa = longint'($signed(a));
            sb = longint'($signed(b));
            q  = 32'(sa / sb);
            r  = 32'(sa % sb);
        end else begin
            q = a / b;
            r = a % b;
        end
        return {r, q};
    endfunction

    // ==================================================================
    // Drive and check helpers
    // ==================================================================
    task automatic drive_req(input mips_ex_pkg::ex_req_t r);
        @(posedge clk);
        req_valid <= 1'b1;
        req       <= r;
        @(posedge clk);
        req_valid <= 1'b0;
    endtask

    task automatic expect_resp(input mips_ex_pkg::ex_req_t r, input logic [31:0] exp_res,
        input logic exp_ovf, input logic exp_hilo);
        mips_ex_pkg::alu_op_e op;
        op = r.op;
        drive_req(r);
        @(negedge clk);    // Response registered on the previous edge
        check_count++;
        assert (resp_valid) else begin
            $display("no response strobe after %s", op.name());
            err_count++;
        end
        assert (resp.result == exp_res) else begin
            $display("mismatch o_resp.result for %s: got %h, expected %h",
                     op.name(), resp.result, exp_res);
            err_count++;
        end
        assert (resp.overflow == exp_ovf) else begin
            $display("mismatch o_resp.overflow for %s: got %h, expected %h",
                     op.name(), resp.overflow, exp_ovf);
            err_count++;
        end
        assert (resp.is_hilo == exp_hilo) else begin
            $display("mismatch o_resp.is_hilo for %s: got %h, expected %h",
                     op.name(), resp.is_hilo, exp_hilo);
            err_count++;
        end
    endtask

    task automatic alu_vector(input mips_ex_pkg::ex_req_t r);
        logic [32:0] m;
        m = alu_model(r);
        expect_resp(r, m[31:0], m[32], 1'b0);
    endtask

    task automatic read_hilo();
        expect_resp(make_req(mips_ex_pkg::MFHI, '0, '0, '0, '0, '0), exp_hi, 1'b0, 1'b1);
        expect_resp(make_req(mips_ex_pkg::MFLO, '0, '0, '0, '0, '0), exp_lo, 1'b0, 1'b1);
    endtask

    // Counts falling edges with busy high from the current falling edge on
    task automatic wait_not_busy(output int n);
        mips_ex_pkg::muldiv_state_e st;
        n = 0;
        while (busy && n < MULDIV_BUDGET) begin
            n++;
            @(negedge clk);
        end
        st = dut_i.u_fsm.state_q;
        assert (!busy) else begin
            $display("multiply/divide still running after %0d cycles, FSM in %s",
                     n, st.name());
            err_count++;
        end
    endtask

    task automatic muldiv_vector(input mips_ex_pkg::alu_op_e op, input logic [31:0] a,
        input logic [31:0] b);
        logic [63:0] m;
        int          n;
        case (op)
            mips_ex_pkg::MULT:  m = mul_model(1'b1, a, b);
            mips_ex_pkg::MULTU: m = mul_model(1'b0, a, b);
            mips_ex_pkg::DIV:   m = div_model(1'b1, a, b);
            default:            m = div_model(1'b0, a, b);
        endcase
        drive_req(make_req(op, a, b, '0, '0, '0));
        @(negedge clk);
        check_count++;
        assert (!resp_valid) else begin
            $display("unexpected response strobe after %s", op.name());
            err_count++;
        end
        assert (busy) else begin
            $display("o_busy did not rise after %s", op.name());
            err_count++;
        end
        wait_not_busy(n);
        assert (n == `MULDIV_ITERS + 2) else begin
            $display("mismatch o_busy cycles for %s: got %h, expected %h",
                     op.name(), n, `MULDIV_ITERS + 2);
            err_count++;
        end
        exp_hi = m[63:32];
        exp_lo = m[31:0];
        read_hilo();
    endtask

    task automatic report_test(input string name);
        $display("%-16s %0d checks, %0d errors", name, check_count - chk_base,
                 err_count - err_base);
        chk_base = check_count;
        err_base = err_count;
    endtask

    // ==================================================================
    // Directed tests
    // ==================================================================
    task automatic reset_state_test();
        @(negedge clk);
        check_count++;
        assert (!busy && !resp_valid) else begin
            $display("o_busy or o_resp_valid high after reset");
            err_count++;
        end
        exp_hi = '0;
        exp_lo = '0;
        read_hilo();
        report_test("reset");
    endtask

    task automatic arith_test();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        for (int i = 0; i < N_ARITH; i++) begin
            a   = next_rand();
            b   = next_rand();
            imm = next_rand();
            alu_vector(make_req(arith_ops[i % 6], a, b, '0, imm[15:0], '0));
        end
        alu_vector(make_req(mips_ex_pkg::ADD, 32'h7fffffff, 32'h1, '0, '0, '0));
        alu_vector(make_req(mips_ex_pkg::SUB, 32'h80000000, 32'h1, '0, '0, '0));
        report_test("arithmetic");
    endtask

    task automatic logic_shift_cmp_test();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] extra;
        logic [31:0] pc;
        for (int i = 0; i < N_LOGIC; i++) begin
            a     = next_rand();
            b     = next_rand();
            extra = next_rand();
            pc    = next_rand();
            alu_vector(make_req(logic_ops[i % 21], a, b, extra[20:16], extra[15:0], pc));
        end
        report_test("logic/shift/cmp");
    endtask

    task automatic multiply_test();
        for (int i = 0; i < 3; i++) begin
            muldiv_vector(mips_ex_pkg::MULT, next_rand(), next_rand());
            muldiv_vector(mips_ex_pkg::MULTU, next_rand(), next_rand());
        end
        muldiv_vector(mips_ex_pkg::MULT, 32'hfffffffd, 32'h7);
        muldiv_vector(mips_ex_pkg::MULT, 32'h80000000, 32'hffffffff);
        report_test("multiply");
    endtask

    task automatic divide_test();
        logic [31:0] a;
        logic [31:0] b;
        a = next_rand() | 32'h80000000;    // Negative dividend
        b = (next_rand() >> 16) | 32'h1;
        muldiv_vector(mips_ex_pkg::DIV, a, b);
        a = next_rand();
        b = next_rand() | 32'h1;
        muldiv_vector(mips_ex_pkg::DIV, a, b);
        muldiv_vector(mips_ex_pkg::DIV, 32'hfffffff9, 32'h2);
        muldiv_vector(mips_ex_pkg::DIV, 32'h7, 32'hfffffffe);
        for (int i = 0; i < 3; i++) begin
            a = next_rand();
            b = (next_rand() >> (4 * i)) | 32'h1;
            muldiv_vector(mips_ex_pkg::DIVU, a, b);
        end
        muldiv_vector(mips_ex_pkg::DIVU, next_rand(), 32'h0);
        report_test("divide");
    endtask

    task automatic overlap_test();
        logic [31:0] a;
        logic [31:0] b;
        logic [63:0] m;
        int          n;
        int          t0;
        a = next_rand();
        b = next_rand();
        m = mul_model(1'b1, a, b);
        drive_req(make_req(mips_ex_pkg::MULT, a, b, '0, '0, '0));
        @(negedge clk);
        t0 = cycles;
        for (int i = 0; i < 5; i++) begin
            check_count++;
            assert (busy) else begin
                $display("o_busy dropped while ADDU requests were in flight");
                err_count++;
            end
            a = next_rand();
            b = next_rand();
            alu_vector(make_req(mips_ex_pkg::ADDU, a, b, '0, '0, '0));
        end
        wait_not_busy(n);
        check_count++;
        assert (cycles - t0 == `MULDIV_ITERS + 2) else begin
            $display("mismatch o_busy cycles for MULT under ADDU traffic: got %h, expected %h",
                     cycles - t0, `MULDIV_ITERS + 2);
            err_count++;
        end
        exp_hi = m[63:32];
        exp_lo = m[31:0];
        read_hilo();
        report_test("overlap");
    endtask

    // ==================================================================
    // Run control
    // ==================================================================
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("run did not complete within %0d cycles", CYCLE_LIMIT);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    initial begin
        req_valid = 1'b0;
        req       = '0;
        @(posedge rst_n);
        reset_state_test();
        arith_test();
        logic_shift_cmp_test();
        multiply_test();
        divide_test();
        overlap_test();
        $display("total %0d checks, %0d errors", check_count, err_count);
        if (err_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

/* sim.f */
+incdir+source
source/mips_ex_pkg.sv
source/mips_alu.sv
source/mips_muldiv_fsm.sv
source/mips_iter_counter.sv
source/mips_hilo_unit.sv
source/mips_ex_top.sv
tests/tb_clock_gen.sv
tests/tb_mips_ex.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f sim.f --top-module tb_mips_ex -o Vtb_mips_ex
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_mips_ex > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TESTBENCH FAILED" "$LOG"; then
    echo "Failure reported in $LOG"
    exit 1
fi

exit 0
